// ==== Makefile ====
# Verilator build and run of the router ingress testbench
# Any variable below can be set on the command line, e.g. make test BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_p4_router_ingress
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check for a pass"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

# The run passes only when the pass line shows up in the output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -x "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== ing_merge_buffer.sv ====
////////////////////////////////////////////////////////////
// Ingress merge buffer
////////////////////////////////////////////////////////////

`default_nettype none

// Holds each port's words until a whole packet is stored, then sends
// whole packets one after another on the shared bus, round-robin
module ing_merge_buffer #(
    parameter int BUF_DEPTH = 16
) (
    input  var logic                             ing,
    input  var logic                             arst_n,

    ing_word_if.snk                              in0,
    ing_word_if.snk                              in1,

    output var logic                             bus_valid,
    output var p4_ingress_pkg::bus_word_t        bus_data,
    output var p4_ingress_pkg::bus_keep_t        bus_keep,
    output var logic                             bus_last,
    output var p4_ingress_pkg::port_id_t         bus_port,

    output var p4_ingress_pkg::cnt_t             bus_pkt_cnt,
    input  var logic                             bus_pkt_cnt_clear,

    output var logic [1:0]                       buf_overflow
);

    localparam int NP = p4_ingress_pkg::NUM_PORTS;
    localparam int BB = p4_ingress_pkg::BUS_BYTES;
    localparam int AW = $clog2(BUF_DEPTH);

    // One extra pointer bit tells a full buffer from an empty one
    typedef logic [AW:0] ptr_t;

    logic [NP-1:0]             in_valid;
    logic [NP-1:0]             in_last;
    p4_ingress_pkg::bus_word_t in_data [NP];
    p4_ingress_pkg::bus_keep_t in_keep [NP];

    p4_ingress_pkg::bus_word_t rd_word [NP];
    logic [BB:0]               rd_tail [NP];
    logic [NP-1:0]             avail;
    logic [NP-1:0]             rd_adv;
    logic [NP-1:0]             pkt_done;

    p4_ingress_pkg::port_id_t  last_port;
    p4_ingress_pkg::port_id_t  sel;
    p4_ingress_pkg::port_id_t  pick;
    p4_ingress_pkg::port_id_t  cur_port;
    logic                      busy;
    logic                      rd_en;
    logic [BB:0]               cur_tail;
    logic                      cur_last;

    assign in_valid   = {in1.valid, in0.valid};
    assign in_last    = {in1.last, in0.last};
    assign in_data[0] = in0.data;
    assign in_data[1] = in1.data;
    assign in_keep[0] = in0.keep;
    assign in_keep[1] = in1.keep;

    ////////////////////////////////////////////////////////////
    // Per-port packet buffers

    for (genvar p = 0; p < NP; p++) begin : g_port
        p4_ingress_pkg::bus_word_t mem_data [BUF_DEPTH];
        // Each entry keeps {last, keep} beside the word
        logic [BB:0]               mem_tail [BUF_DEPTH];
        ptr_t                      wr_ptr;
        ptr_t                      pkt_start;
        ptr_t                      rd_ptr;
        logic [AW:0]               pkt_cnt;
        logic                      discard;
        logic                      ovf_q;
        logic                      full;
        logic                      wr_ok;
        logic                      ovf_hit;
        logic                      pkt_inc;

        assign full    = (wr_ptr - rd_ptr) == ptr_t'(BUF_DEPTH);
        assign wr_ok   = in_valid[p] && !discard && !full;
        assign ovf_hit = in_valid[p] && !discard && full;
        assign pkt_inc = wr_ok && in_last[p];

        always_ff @(posedge ing) begin
            if (wr_ok) begin
                mem_data[wr_ptr[AW-1:0]] <= in_data[p];
                mem_tail[wr_ptr[AW-1:0]] <= {in_last[p], in_keep[p]};
            end
        end

        always_ff @(posedge ing or negedge arst_n) begin
            if (!arst_n) begin
                wr_ptr    <= '0;
                pkt_start <= '0;
                rd_ptr    <= '0;
                pkt_cnt   <= '0;
                discard   <= 1'b0;
                ovf_q     <= 1'b0;
            end else begin
                if (ovf_hit) begin
                    // Throw away the partial packet, skip the rest of it
                    wr_ptr  <= pkt_start;
                    ovf_q   <= 1'b1;
                    discard <= !in_last[p];
                end else if (discard) begin
                    if (in_valid[p] && in_last[p]) begin
                        discard <= 1'b0;
                    end
                end else if (wr_ok) begin
                    wr_ptr <= wr_ptr + 1'b1;
                    if (in_last[p]) begin
                        pkt_start <= wr_ptr + 1'b1;
                    end
                end
                if (rd_adv[p]) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                // Stored and dispatched packets can land in the same cycle
                if (pkt_inc && !pkt_done[p]) begin
                    pkt_cnt <= pkt_cnt + 1'b1;
                end else if (!pkt_inc && pkt_done[p]) begin
                    pkt_cnt <= pkt_cnt - 1'b1;
                end
            end
        end

        assign rd_word[p]      = mem_data[rd_ptr[AW-1:0]];
        assign rd_tail[p]      = mem_tail[rd_ptr[AW-1:0]];
        assign avail[p]        = (pkt_cnt != '0);
        assign rd_adv[p]       = rd_en && (cur_port == p4_ingress_pkg::port_id_t'(p));
        assign pkt_done[p]     = rd_adv[p] && cur_last;
        assign buf_overflow[p] = ovf_q;
    end

    ////////////////////////////////////////////////////////////
    // Dispatcher

    // The port that did not send last goes first when it has a packet
    assign pick     = avail[~last_port] ? ~last_port : last_port;
    assign rd_en    = busy || (avail != '0);
    assign cur_port = busy ? sel : pick;
    assign cur_tail = rd_tail[cur_port];
    assign cur_last = cur_tail[BB];

    always_ff @(posedge ing or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            sel       <= '0;
            last_port <= '1;
        end else if (rd_en) begin
            if (cur_last) begin
                busy      <= 1'b0;
                last_port <= cur_port;
            end else begin
                busy <= 1'b1;
                sel  <= cur_port;
            end
        end
    end

    always_ff @(posedge ing or negedge arst_n) begin
        if (!arst_n) begin
            bus_valid   <= 1'b0;
            bus_last    <= 1'b0;
            bus_pkt_cnt <= '0;
        end else begin
            bus_valid   <= rd_en;
            bus_last    <= rd_en && cur_last;
            bus_pkt_cnt <= p4_ingress_pkg::cnt_step(bus_pkt_cnt, bus_pkt_cnt_clear,
                                                    bus_valid && bus_last);
        end
    end

    always_ff @(posedge ing) begin
        if (rd_en) begin
            bus_data <= rd_word[cur_port];
            bus_keep <= cur_tail[BB-1:0];
            bus_port <= cur_port;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks

    // Keep is filled from lane 0 on every word leaving the buffer
    a_bus_keep_contig : assert property (
        @(posedge ing) disable iff (!arst_n)
        bus_valid |-> ((bus_keep != '0) && ((bus_keep & (bus_keep + 1'b1)) == '0))
    );

    // A read only ever targets a port holding a complete packet
    a_read_complete : assert property (
        @(posedge ing) disable iff (!arst_n)
        rd_en |-> avail[cur_port]
    );

endmodule

`default_nettype wire

// ==== ing_port_adapt.sv ====
////////////////////////////////////////////////////////////
// Ingress port width adapter
////////////////////////////////////////////////////////////

`default_nettype none

// Packs narrow port words into 8-byte bus words, applies the port
// enable per packet and keeps the packet and drop counters
module ing_port_adapt #(
    parameter type in_word_t = logic [7:0]
) (
    input  var logic                  ing,
    input  var logic                  arst_n,

    input  var logic                  in_valid,
    input  var in_word_t              in_data,
    input  var logic                  in_last,

    input  var logic                  enable,
    input  var logic                  cnt_clear,

    ing_word_if.src                   out,

    output var p4_ingress_pkg::cnt_t  pkt_cnt,
    output var p4_ingress_pkg::cnt_t  drop_cnt
);

    ////////////////////////////////////////////////////////////
    // Local sizes

    // Bytes carried by one input strobe
    localparam int IN_BYTES = $bits(in_word_t) / 8;
    // Byte count has to reach BUS_BYTES itself
    localparam int CW = $clog2(p4_ingress_pkg::BUS_BYTES + 1);

    logic [CW-1:0]             byte_cnt;
    logic [CW-1:0]             next_cnt;
    p4_ingress_pkg::bus_word_t pack_data;
    p4_ingress_pkg::bus_word_t next_data;
    logic                      in_pkt;
    logic                      pkt_pass;
    logic                      cur_pass;
    logic                      word_done;

    ////////////////////////////////////////////////////////////
    // Packing

    always_comb begin
        // A fresh word starts from zero so unused lanes stay clean
        next_data = (byte_cnt == '0) ? '0 : pack_data;
        // New bytes go in above the ones already collected
        next_data[byte_cnt * 8 +: $bits(in_word_t)] = in_data;
        next_cnt  = byte_cnt + CW'(IN_BYTES);
    end

    // The word closes when it is full or the packet ends
    assign word_done = (next_cnt == CW'(p4_ingress_pkg::BUS_BYTES)) || in_last;

    // Enable only counts on the first word, later words follow that decision
    assign cur_pass = in_pkt ? pkt_pass : enable;

    ////////////////////////////////////////////////////////////
    // Control state and counters

    always_ff @(posedge ing or negedge arst_n) begin
        if (!arst_n) begin
            byte_cnt  <= '0;
            in_pkt    <= 1'b0;
            pkt_pass  <= 1'b0;
            out.valid <= 1'b0;
            pkt_cnt   <= '0;
            drop_cnt  <= '0;
        end else begin
            // Output strobe lands one cycle after the closing input strobe
            out.valid <= in_valid && word_done && cur_pass;
            if (in_valid) begin
                in_pkt   <= !in_last;
                byte_cnt <= word_done ? '0 : next_cnt;
                if (!in_pkt) begin
                    pkt_pass <= enable;
                end
            end
            // One count per accepted packet, taken on its last word
            pkt_cnt <= p4_ingress_pkg::cnt_step(pkt_cnt, cnt_clear,
                                                in_valid && in_last && cur_pass);
            // One count per refused packet, taken on its first word
            drop_cnt <= p4_ingress_pkg::cnt_step(drop_cnt, cnt_clear,
                                                 in_valid && !in_pkt && !enable);
        end
    end

    ////////////////////////////////////////////////////////////
    // Payload registers

    always_ff @(posedge ing) begin
        if (in_valid) begin
            pack_data <= next_data;
        end
        if (in_valid && word_done) begin
            out.data <= next_data;
            out.keep <= p4_ingress_pkg::keep_from_count(next_cnt);
            out.last <= in_last;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks

    // Input widths divide the bus word, so a strobe never spills past 8 bytes
    a_byte_cnt_bound : assert property (
        @(posedge ing) disable iff (!arst_n)
        in_valid |-> (next_cnt <= CW'(p4_ingress_pkg::BUS_BYTES))
    );

endmodule

`default_nettype wire

// ==== ing_word_if.sv ====
////////////////////////////////////////////////////////////
// Adapted word stream
////////////////////////////////////////////////////////////

`default_nettype none

// One 8-byte word stream between a port adapter and the merge buffer
// A word moves in every cycle where valid is high, there is no ready
interface ing_word_if;

    logic                      valid;
    p4_ingress_pkg::bus_word_t data;
    p4_ingress_pkg::bus_keep_t keep;
    logic                      last;

    // Driven by the port adapter
    modport src (
        output valid,
        output data,
        output keep,
        output last
    );

    // Consumed by the merge buffer
    modport snk (
        input valid,
        input data,
        input keep,
        input last
    );

endinterface

`default_nettype wire

// ==== p4_ingress_pkg.sv ====
////////////////////////////////////////////////////////////
// Router ingress shared types
////////////////////////////////////////////////////////////

`default_nettype none

package p4_ingress_pkg;

    // Geometry of the shared ingress bus
    localparam int BUS_BYTES = 8;
    localparam int BUS_WIDTH = BUS_BYTES * 8;
    localparam int NUM_PORTS = 2;
    localparam int CNT_WIDTH = 32;

    // Byte 0 sits in the lowest lane and is the earliest byte on the wire
    typedef logic [BUS_WIDTH-1:0] bus_word_t;
    // Byte-valid mask, always filled from lane 0 upwards
    typedef logic [BUS_BYTES-1:0] bus_keep_t;
    typedef logic [$clog2(NUM_PORTS)-1:0] port_id_t;
    typedef logic [CNT_WIDTH-1:0] cnt_t;

    // Next value of a saturating counter; clear wins over increment
    function automatic cnt_t cnt_step(cnt_t cur, logic clr, logic inc);
        if (clr) begin
            return '0;
        end
        if (inc && (cur != '1)) begin
            return cur + 1'b1;
        end
        return cur;
    endfunction

    // Keep mask with the lowest n lanes set
    function automatic bus_keep_t keep_from_count(int unsigned n);
        bus_keep_t k;
        for (int i = 0; i < BUS_BYTES; i++) begin
            k[i] = (i < n);
        end
        return k;
    endfunction

endpackage

`default_nettype wire

// ==== p4_router_ingress.sv ====
////////////////////////////////////////////////////////////
// Router ingress top level
////////////////////////////////////////////////////////////

`default_nettype none

// Two port adapters feed the merge buffer, which drives the 64-bit bus
module p4_router_ingress #(
    parameter int MTU_BYTES = 64
) (
    input  var logic                       ing,
    input  var logic                       arst_n,

    input  var logic                       port0_valid,
    input  var logic [7:0]                 port0_data,
    input  var logic                       port0_last,

    input  var logic                       port1_valid,
    input  var logic [31:0]                port1_data,
    input  var logic                       port1_last,

    input  var logic [1:0]                 port_enable,
    input  var logic [1:0]                 cnt_clear,

    output var p4_ingress_pkg::cnt_t       pkt_cnt0,
    output var p4_ingress_pkg::cnt_t       pkt_cnt1,
    output var p4_ingress_pkg::cnt_t       drop_cnt0,
    output var p4_ingress_pkg::cnt_t       drop_cnt1,

    output var logic                       bus_valid,
    output var p4_ingress_pkg::bus_word_t  bus_data,
    output var p4_ingress_pkg::bus_keep_t  bus_keep,
    output var logic                       bus_last,
    output var p4_ingress_pkg::port_id_t   bus_port,

    output var p4_ingress_pkg::cnt_t       bus_pkt_cnt,
    input  var logic                       bus_pkt_cnt_clear,

    output var logic [1:0]                 buf_overflow
);

    // Each port buffer holds two MTUs, rounded up to a power of two
    localparam int MTU_WORDS = (MTU_BYTES + p4_ingress_pkg::BUS_BYTES - 1)
                               / p4_ingress_pkg::BUS_BYTES;
    localparam int BUF_DEPTH = 2 ** $clog2(2 * MTU_WORDS);

    ing_word_if word0 ();
    ing_word_if word1 ();

    // Port 0 carries one byte per strobe
    ing_port_adapt #(
        .in_word_t ( logic [7:0] )
    ) port0_adapt_inst (
        .ing       ( ing            ),
        .arst_n    ( arst_n         ),
        .in_valid  ( port0_valid    ),
        .in_data   ( port0_data     ),
        .in_last   ( port0_last     ),
        .enable    ( port_enable[0] ),
        .cnt_clear ( cnt_clear[0]   ),
        .out       ( word0          ),
        .pkt_cnt   ( pkt_cnt0       ),
        .drop_cnt  ( drop_cnt0      )
    );

    // Port 1 carries four bytes per strobe
    ing_port_adapt #(
        .in_word_t ( logic [31:0] )
    ) port1_adapt_inst (
        .ing       ( ing            ),
        .arst_n    ( arst_n         ),
        .in_valid  ( port1_valid    ),
        .in_data   ( port1_data     ),
        .in_last   ( port1_last     ),
        .enable    ( port_enable[1] ),
        .cnt_clear ( cnt_clear[1]   ),
        .out       ( word1          ),
        .pkt_cnt   ( pkt_cnt1       ),
        .drop_cnt  ( drop_cnt1      )
    );

    ing_merge_buffer #(
        .BUF_DEPTH ( BUF_DEPTH )
    ) merge_buffer_inst (
        .ing               ( ing               ),
        .arst_n            ( arst_n            ),
        .in0               ( word0             ),
        .in1               ( word1             ),
        .bus_valid         ( bus_valid         ),
        .bus_data          ( bus_data          ),
        .bus_keep          ( bus_keep          ),
        .bus_last          ( bus_last          ),
        .bus_port          ( bus_port          ),
        .bus_pkt_cnt       ( bus_pkt_cnt       ),
        .bus_pkt_cnt_clear ( bus_pkt_cnt_clear ),
        .buf_overflow      ( buf_overflow      )
    );

endmodule

`default_nettype wire

// ==== project.f ====
p4_ingress_pkg.sv
ing_word_if.sv
ing_port_adapt.sv
ing_merge_buffer.sv
p4_router_ingress.sv
tb_ingress_checker.sv
tb_p4_router_ingress.sv

// ==== tb_ingress_checker.sv ====
////////////////////////////////////////////////////////////
// Ingress bus checker
////////////////////////////////////////////////////////////

`default_nettype none

// Watches the ingress bus and compares every word with the expected words
// of the accepted packets
// Counter checks run on request from the test sequence
module tb_ingress_checker (
    input  var logic                      ing,
    input  var logic                      arst_n,
    input  var logic                      bus_valid,
    input  var p4_ingress_pkg::bus_word_t bus_data,
    input  var p4_ingress_pkg::bus_keep_t bus_keep,
    input  var logic                      bus_last,
    input  var p4_ingress_pkg::port_id_t  bus_port,
    input  var p4_ingress_pkg::cnt_t      bus_pkt_cnt,
    input  var p4_ingress_pkg::cnt_t      pkt_cnt0,
    input  var p4_ingress_pkg::cnt_t      pkt_cnt1,
    input  var p4_ingress_pkg::cnt_t      drop_cnt0,
    input  var p4_ingress_pkg::cnt_t      drop_cnt1,
    input  var logic [1:0]                buf_overflow,
    output var int                        pending,
    output var int                        words_seen,
    output var int                        pkts_seen
);

    typedef logic [7:0] byte_q_t [$];

    // Expected bytes per port and the byte count of each packet in order
    byte_q_t  exp_bytes0;
    byte_q_t  exp_bytes1;
    int       exp_len0 [$];
    int       exp_len1 [$];
    byte_q_t  cur_bytes;
    logic     in_pkt = 1'b0;
    logic     cur_port;
    int       word_idx;
    int       pushed = 0;
    int       bus_base = 0;
    int       word_errs = 0;
    int       cnt_errs = 0;

    assign pending = pushed - pkts_seen;

    ////////////////////////////////////////////////////////////
    // Reference model

    // Word idx of a packet puts byte 0 in lane 0 and leaves lanes past the end empty
    function automatic void expected_word(input byte_q_t bytes, input int idx,
                                          output p4_ingress_pkg::bus_word_t data,
                                          output p4_ingress_pkg::bus_keep_t keep,
                                          output logic last);
        int pos;
        data = '0;
        keep = '0;
        for (int i = 0; i < p4_ingress_pkg::BUS_BYTES; i++) begin
            pos = idx * p4_ingress_pkg::BUS_BYTES + i;
            if (pos < bytes.size()) begin
                data[i*8 +: 8] = bytes[pos];
                keep[i] = 1'b1;
            end
        end
        last = ((idx + 1) * p4_ingress_pkg::BUS_BYTES >= bytes.size());
    endfunction

    ////////////////////////////////////////////////////////////
    // Expectations from the stimulus

    task automatic expect_byte(input p4_ingress_pkg::port_id_t p, input logic [7:0] b);
        if (p == 1'b0) begin
            exp_bytes0.push_back(b);
        end else begin
            exp_bytes1.push_back(b);
        end
    endtask

    // The packet is complete in the queue once its byte count is known
    task automatic close_packet(input p4_ingress_pkg::port_id_t p, input int nbytes);
        if (p == 1'b0) begin
            exp_len0.push_back(nbytes);
        end else begin
            exp_len1.push_back(nbytes);
        end
        pushed++;
    endtask

    ////////////////////////////////////////////////////////////
    // Bus word comparison

    task automatic check_bus_word();
        p4_ingress_pkg::bus_word_t exp_data;
        p4_ingress_pkg::bus_word_t lane_mask;
        p4_ingress_pkg::bus_keep_t exp_keep;
        logic                      exp_last;
        int                        n;
        if (!in_pkt) begin
            // First word of a packet picks the oldest packet of that port
            cur_bytes = {};
            cur_port  = bus_port;
            word_idx  = 0;
            in_pkt    = 1'b1;
            if (bus_port == 1'b0 && exp_len0.size() > 0) begin
                n = exp_len0.pop_front();
                repeat (n) cur_bytes.push_back(exp_bytes0.pop_front());
            end else if (bus_port == 1'b1 && exp_len1.size() > 0) begin
                n = exp_len1.pop_front();
                repeat (n) cur_bytes.push_back(exp_bytes1.pop_front());
            end else begin
                word_errs++;
                $display("error %0t: packet on port %0d that was never sent", $time, bus_port);
            end
        end else if (bus_port != cur_port) begin
            word_errs++;
            $display("error %0t: port %0d interleaved into a packet from port %0d",
                     $time, bus_port, cur_port);
        end
        expected_word(cur_bytes, word_idx, exp_data, exp_keep, exp_last);
        lane_mask = '0;
        for (int i = 0; i < p4_ingress_pkg::BUS_BYTES; i++) begin
            lane_mask[i*8 +: 8] = {8{exp_keep[i]}};
        end
        // Only lanes marked in keep carry packet bytes
        if (((bus_data & lane_mask) !== exp_data) || (bus_keep !== exp_keep) ||
            (bus_last !== exp_last)) begin
            word_errs++;
            $display("error %0t: port %0d word %0d data %h keep %b last %b, expected %h %b %b",
                     $time, bus_port, word_idx, bus_data & lane_mask, bus_keep, bus_last,
                     exp_data, exp_keep, exp_last);
        end
        word_idx++;
        words_seen++;
        if (bus_last) begin
            in_pkt = 1'b0;
            pkts_seen++;
        end
    endtask

    // Outputs are registered on the rising edge and stable at the falling one
    initial begin
        words_seen = 0;
        pkts_seen  = 0;
        forever begin
            @(negedge ing);
            if (arst_n && bus_valid) begin
                check_bus_word();
            end else if (arst_n && in_pkt) begin
                word_errs++;
                $display("error %0t: gap inside a packet from port %0d", $time, cur_port);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Counter checks

    task automatic compare_count(input string name, input p4_ingress_pkg::cnt_t got,
                                 input p4_ingress_pkg::cnt_t exp);
        if (got !== exp) begin
            cnt_errs++;
            $display("error %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_counters(input p4_ingress_pkg::cnt_t e_pkt0,
                                  input p4_ingress_pkg::cnt_t e_pkt1,
                                  input p4_ingress_pkg::cnt_t e_drop0,
                                  input p4_ingress_pkg::cnt_t e_drop1,
                                  input logic [1:0] e_ovf);
        compare_count("pkt_cnt0", pkt_cnt0, e_pkt0);
        compare_count("pkt_cnt1", pkt_cnt1, e_pkt1);
        compare_count("drop_cnt0", drop_cnt0, e_drop0);
        compare_count("drop_cnt1", drop_cnt1, e_drop1);
        // Bus count follows the packets seen since the last clear
        compare_count("bus_pkt_cnt", bus_pkt_cnt, p4_ingress_pkg::cnt_t'(pkts_seen - bus_base));
        if (buf_overflow !== e_ovf) begin
            cnt_errs++;
            $display("error %0t: buf_overflow is %b, expected %b", $time, buf_overflow, e_ovf);
        end
    endtask

    task automatic restart_bus_count();
        bus_base = pkts_seen;
    endtask

    function automatic int error_count();
        return word_errs + cnt_errs;
    endfunction

endmodule

`default_nettype wire

// ==== tb_p4_router_ingress.sv ====
////////////////////////////////////////////////////////////
// Router ingress testbench
////////////////////////////////////////////////////////////

`default_nettype none

module tb_p4_router_ingress;

    // Buffer depth is two MTUs of 64 bytes in 8-byte words and already a power of two
    localparam int BUF_DEPTH = 16;

    logic                      ing;
    logic                      arst_n;
    logic                      port0_valid;
    logic [7:0]                port0_data;
    logic                      port0_last;
    logic                      port1_valid;
    logic [31:0]               port1_data;
    logic                      port1_last;
    logic [1:0]                port_enable;
    logic [1:0]                cnt_clear;
    logic                      bus_pkt_cnt_clear;
    p4_ingress_pkg::cnt_t      pkt_cnt0;
    p4_ingress_pkg::cnt_t      pkt_cnt1;
    p4_ingress_pkg::cnt_t      drop_cnt0;
    p4_ingress_pkg::cnt_t      drop_cnt1;
    logic                      bus_valid;
    p4_ingress_pkg::bus_word_t bus_data;
    p4_ingress_pkg::bus_keep_t bus_keep;
    logic                      bus_last;
    p4_ingress_pkg::port_id_t  bus_port;
    p4_ingress_pkg::cnt_t      bus_pkt_cnt;
    logic [1:0]                buf_overflow;
    int                        pending;
    int                        words_seen;
    int                        pkts_seen;

    int                        bytes_sent = 0;
    int                        cycles;
    p4_ingress_pkg::cnt_t      exp_pkt [2];
    p4_ingress_pkg::cnt_t      exp_drop [2];
    logic [1:0]                exp_ovf;

    p4_router_ingress #(
        .MTU_BYTES ( 64 )
    ) p4_router_ingress_inst (.*);

    tb_ingress_checker checker_inst (.*);

    initial begin
        ing = 1'b0;
        forever #2 ing = ~ing;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers

    // Enable counts on the first word; a packet over BUF_DEPTH words is lost
    function automatic logic admit_packet(input p4_ingress_pkg::port_id_t p, input logic en,
                                          input int words);
        if (!en) begin
            exp_drop[p]++;
            return 1'b0;
        end
        exp_pkt[p]++;
        if (words > BUF_DEPTH) begin
            exp_ovf[p] = 1'b1;
            return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic send_port0(input int len);
        logic [7:0] b;
        logic       take;
        take = 1'b0;
        for (int i = 0; i < len; i++) begin
            @(negedge ing);
            if (i == 0) begin
                take = admit_packet(1'b0, port_enable[0], (len + 7) / 8);
            end
            b = 8'($urandom);
            port0_valid = 1'b1;
            port0_data  = b;
            port0_last  = (i == len - 1);
            bytes_sent++;
            if (take) begin
                checker_inst.expect_byte(1'b0, b);
            end
        end
        if (take) begin
            checker_inst.close_packet(1'b0, len);
        end
        @(negedge ing);
        port0_valid = 1'b0;
        port0_last  = 1'b0;
    endtask

    // Port 1 word carries its earliest byte in bits 7:0
    task automatic send_port1(input int words);
        logic [31:0] d;
        logic        take;
        take = 1'b0;
        for (int i = 0; i < words; i++) begin
            @(negedge ing);
            if (i == 0) begin
                take = admit_packet(1'b1, port_enable[1], (words * 4 + 7) / 8);
            end
            d = $urandom;
            port1_valid = 1'b1;
            port1_data  = d;
            port1_last  = (i == words - 1);
            bytes_sent += 4;
            for (int k = 0; k < 4 && take; k++) begin
                checker_inst.expect_byte(1'b1, d[k*8 +: 8]);
            end
        end
        if (take) begin
            checker_inst.close_packet(1'b1, words * 4);
        end
        @(negedge ing);
        port1_valid = 1'b0;
        port1_last  = 1'b0;
    endtask

    // Waits until every expected packet has left the bus
    task automatic wait_drained();
        while (pending != 0) begin
            @(posedge ing);
        end
        @(negedge ing);
    endtask

    task automatic check_all();
        checker_inst.check_counters(exp_pkt[0], exp_pkt[1], exp_drop[0], exp_drop[1], exp_ovf);
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        arst_n            = 1'b0;
        port0_valid       = 1'b0;
        port0_data        = '0;
        port0_last        = 1'b0;
        port1_valid       = 1'b0;
        port1_data        = '0;
        port1_last        = 1'b0;
        port_enable       = 2'b11;
        cnt_clear         = 2'b00;
        bus_pkt_cnt_clear = 1'b0;
        exp_pkt           = '{default: '0};
        exp_drop          = '{default: '0};
        exp_ovf           = 2'b00;
        void'($urandom(45));
        repeat (2) @(posedge ing);
        @(negedge ing);
        arst_n = 1'b1;

        // One packet at a time on each port
        for (int i = 0; i < 4; i++) begin
            send_port0(1 + int'($urandom % 64));
            wait_drained();
            send_port1(1 + int'($urandom % 16));
            wait_drained();
        end
        check_all();

        // Both ports busy together
        fork
            repeat (6) send_port0(1 + int'($urandom % 64));
            repeat (6) send_port1(1 + int'($urandom % 16));
        join
        wait_drained();
        check_all();

        // Disabled ports; port 1 is enabled again after its first word
        port_enable[0] = 1'b0;
        send_port0(20);
        port_enable[0] = 1'b1;
        send_port0(1 + int'($urandom % 64));
        port_enable[1] = 1'b0;
        fork
            send_port1(6);
            begin
                repeat (2) @(negedge ing);
                port_enable[1] = 1'b1;
            end
        join
        send_port1(1 + int'($urandom % 16));
        wait_drained();
        check_all();

        // 36 words of 4 bytes fill 18 bus words which is more than the buffer holds
        send_port1(36);
        wait_drained();
        send_port1(1 + int'($urandom % 16));
        send_port0(1 + int'($urandom % 64));
        wait_drained();
        check_all();

        // Clear every counter and count again from zero
        cnt_clear         = 2'b11;
        bus_pkt_cnt_clear = 1'b1;
        @(negedge ing);
        cnt_clear         = 2'b00;
        bus_pkt_cnt_clear = 1'b0;
        exp_pkt           = '{default: '0};
        exp_drop          = '{default: '0};
        checker_inst.restart_bus_count();
        check_all();
        fork
            repeat (3) send_port0(1 + int'($urandom % 64));
            repeat (3) send_port1(1 + int'($urandom % 16));
        join
        wait_drained();
        check_all();

        $display("errors: %0d, bus words checked: %0d, bus packets checked: %0d",
                 checker_inst.error_count(), words_seen, pkts_seen);
        if (checker_inst.error_count() == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // The limit grows with every byte sent
    initial begin
        cycles = 0;
        while (cycles <= 40 * bytes_sent + 500) begin
            @(posedge ing);
            cycles++;
        end
        $display("timeout: the bus did not drain within %0d cycles", cycles);
        $display("errors: %0d, run stopped by the timeout", checker_inst.error_count());
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
